/* Makefile */
TOP = vfb_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+source
source/vfb_pkg.sv
source/vfb_arbiter.sv
source/frame_buffer_table.sv
source/frame_sequencer.sv
source/frame_writer.sv
source/frame_reader.sv
source/video_frame_buffer.sv
test/vfb_assert.sv
test/vfb_tb.sv

/* source/frame_buffer_table.sv */
`timescale 1ns/1ps
`include "vfb_defines.svh"

module frame_buffer_table import vfb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      up_select_i,
    input  logic      up_release_i,
    input  logic      dn_select_i,
    input  logic      dn_release_i,
    output mem_addr_t up_base_o,
    output mem_addr_t dn_base_o
);

    buf_state_t buf_q [`VFB_NUM_BUFFERS];
    buf_idx_t   up_idx_q;
    buf_idx_t   dn_idx_q;
    buf_idx_t   up_pick;
    buf_idx_t   dn_pick;

    function automatic mem_addr_t base_of(input buf_idx_t idx);
        return mem_addr_t'(idx) * mem_addr_t'(`VFB_BUFFER_STRIDE);
    endfunction

    // first class that has a member wins, lowest index inside a class
    function automatic buf_idx_t pick_buf(input buf_state_t c0, input buf_state_t c1,
                                          input buf_state_t c2);
        buf_state_t order [3];
        buf_idx_t   sel;
        logic       hit;
        order[0] = c0;
        order[1] = c1;
        order[2] = c2;
        sel = '0;
        hit = 1'b0;
        for (int p = 0; p < 3; p++) begin
            for (int b = 0; b < `VFB_NUM_BUFFERS; b++) begin
                if (!hit && buf_q[b] == order[p]) begin
                    sel = buf_idx_t'(b);
                    hit = 1'b1;
                end
            end
        end
        return sel;
    endfunction

    always_comb begin
        up_pick = pick_buf(BUF_DISPLAYED, BUF_AVAILABLE, BUF_UPDATED);
        dn_pick = pick_buf(BUF_UPDATED, BUF_AVAILABLE, BUF_DISPLAYED);
    end

    // the arbiter keeps the two sides from touching the table together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `VFB_NUM_BUFFERS; i++)
                buf_q[i] <= BUF_AVAILABLE;
            up_idx_q <= '0;
            dn_idx_q <= '0;
            up_base_o <= '0;
            dn_base_o <= '0;
        end else begin
            if (up_select_i) begin
                buf_q[up_pick] <= BUF_WRITE_BUSY;
                up_idx_q <= up_pick;
                up_base_o <= base_of(up_pick);
            end else if (up_release_i) begin
                buf_q[up_idx_q] <= BUF_UPDATED;
            end

            if (dn_select_i) begin
                buf_q[dn_pick] <= BUF_READ_BUSY;
                dn_idx_q <= dn_pick;
                dn_base_o <= base_of(dn_pick);
            end else if (dn_release_i) begin
                buf_q[dn_idx_q] <= BUF_DISPLAYED;
            end
        end
    end

endmodule

/* source/frame_reader.sv */
`timescale 1ns/1ps
`include "vfb_defines.svh"

module frame_reader import vfb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  mem_addr_t base_addr_i,
    input  logic      grant_i,
    output logic      req_o,
    output logic      cmd_en_o,
    output mem_addr_t addr_o,
    input  mem_data_t rd_data_i,
    input  logic      rd_data_valid_i,
    input  logic      store_queue_full_i,
    output logic      store_wr_en_o,
    output mem_data_t store_queue_data_o,
    output logic      done_o
);

    localparam int PTR_W = $clog2(`VFB_BURST);

    burst_state_t     state_q;
    pix_addr_t        issue_q;
    pix_addr_t        deliv_q;
    mem_data_t        fifo_mem [`VFB_BURST];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             pop;
    logic             settled;

    assign pop = (count_q != '0) && !store_queue_full_i;
    // nothing in flight and nothing buffered
    assign settled = deliv_q == issue_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= BURST_IDLE;
            issue_q <= '0;
            deliv_q <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= pop && (deliv_q == pix_addr_t'(`VFB_FRAME_WORDS - 1));
            if (pop)
                deliv_q <= deliv_q + 1'b1;
            case (state_q)
                BURST_IDLE:
                    if (start_i) begin
                        issue_q <= '0;
                        deliv_q <= '0;
                        state_q <= BURST_REQ;
                    end
                BURST_REQ:
                    if (grant_i)
                        state_q <= BURST_ISSUE;
                BURST_ISSUE: begin
                    issue_q <= issue_q + 1'b1;
                    if (issue_q[PTR_W-1:0] == PTR_W'(`VFB_BURST - 1))
                        state_q <= BURST_DRAIN;
                end
                // wait for the fifo to empty before the next burst
                BURST_DRAIN:
                    if (settled) begin
                        if (issue_q == pix_addr_t'(`VFB_FRAME_WORDS))
                            state_q <= BURST_IDLE;
                        else
                            state_q <= BURST_REQ;
                    end
                default:
                    state_q <= BURST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_data_valid_i)
            fifo_mem[wr_ptr_q] <= rd_data_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (rd_data_valid_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({rd_data_valid_i, pop})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign req_o = (state_q == BURST_REQ) || (state_q == BURST_ISSUE);
    assign cmd_en_o = state_q == BURST_ISSUE;
    assign addr_o = base_addr_i + mem_addr_t'(issue_q);
    assign store_wr_en_o = pop;
    assign store_queue_data_o = fifo_mem[rd_ptr_q];

endmodule

/* source/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer import vfb_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic mem_ready_i,
    input  logic grant_i,
    output logic req_o,
    output logic select_o,
    output logic release_o,
    output logic start_o,
    input  logic done_i
);

    seq_state_t state_q;
    seq_state_t state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= SEQ_IDLE;
        else
            state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE:
                state_d = SEQ_START_WAIT;
            // counter stays at its limit, so later frames pass straight through
            SEQ_START_WAIT:
                if (mem_ready_i)
                    state_d = SEQ_LOCK;
            SEQ_LOCK:
                if (grant_i)
                    state_d = SEQ_SELECT;
            SEQ_SELECT:
                state_d = SEQ_START;
            SEQ_START:
                state_d = SEQ_XFER_WAIT;
            SEQ_XFER_WAIT:
                if (done_i)
                    state_d = SEQ_RELEASE_WAIT;
            SEQ_RELEASE_WAIT:
                if (grant_i)
                    state_d = SEQ_RELEASE;
            SEQ_RELEASE:
                state_d = SEQ_IDLE;
            default:
                state_d = SEQ_IDLE;
        endcase
    end

    // table held from lock through select, and again for release
    assign req_o = (state_q == SEQ_LOCK) || (state_q == SEQ_SELECT)
                || (state_q == SEQ_RELEASE_WAIT) || (state_q == SEQ_RELEASE);
    assign select_o = state_q == SEQ_SELECT;
    assign release_o = state_q == SEQ_RELEASE;
    assign start_o = state_q == SEQ_START;

endmodule

/* source/frame_writer.sv */
`timescale 1ns/1ps
`include "vfb_defines.svh"

module frame_writer import vfb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start_i,
    input  mem_addr_t base_addr_i,
    input  logic      grant_i,
    output logic      req_o,
    output logic      load_read_rdy_o,
    output pix_addr_t load_mem_addr_o,
    input  logic      load_command_valid_i,
    input  mem_data_t load_pixel_data_i,
    output logic      cmd_en_o,
    output mem_addr_t addr_o,
    output mem_data_t wr_data_o,
    output logic      done_o
);

    localparam int PTR_W = $clog2(`VFB_BURST);

    burst_state_t state_q;
    logic         busy_q;
    pix_addr_t    fetch_q;
    logic         writing;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= BURST_IDLE;
            busy_q <= 1'b0;
            fetch_q <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                // idle also serves as the gap between bursts
                BURST_IDLE:
                    if (start_i) begin
                        busy_q <= 1'b1;
                        fetch_q <= '0;
                        state_q <= BURST_REQ;
                    end else if (busy_q) begin
                        state_q <= BURST_REQ;
                    end
                BURST_REQ:
                    if (grant_i)
                        state_q <= BURST_ISSUE;
                BURST_ISSUE: begin
                    fetch_q <= fetch_q + 1'b1;
                    if (fetch_q[PTR_W-1:0] == PTR_W'(`VFB_BURST - 1))
                        state_q <= BURST_DRAIN;
                end
                // last write of the burst
                BURST_DRAIN: begin
                    state_q <= BURST_IDLE;
                    if (fetch_q == pix_addr_t'(`VFB_FRAME_WORDS)) begin
                        busy_q <= 1'b0;
                        done_o <= 1'b1;
                    end
                end
                default:
                    state_q <= BURST_IDLE;
            endcase
        end
    end

    assign writing = (state_q == BURST_ISSUE) || (state_q == BURST_DRAIN);
    assign req_o = writing || (state_q == BURST_REQ);
    assign load_read_rdy_o = state_q == BURST_ISSUE;
    assign load_mem_addr_o = fetch_q;

    // queue answers the previous fetch, so that word goes out now
    assign cmd_en_o = writing && load_command_valid_i;
    assign addr_o = base_addr_i + mem_addr_t'(fetch_q - 1'b1);
    assign wr_data_o = load_pixel_data_i;

endmodule

/* source/vfb_arbiter.sv */
`timescale 1ns/1ps

module vfb_arbiter import vfb_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  req_vec_t req_i,
    output req_vec_t grant_o
);

    // last peer served, the search begins one above it
    logic [1:0] last_q;
    logic [1:0] cand;
    logic [1:0] pick_idx;
    logic       pick_found;

    always_comb begin
        pick_idx = last_q;
        pick_found = 1'b0;
        cand = last_q;
        for (int k = 1; k <= 4; k++) begin
            cand = last_q + 2'(k);
            if (!pick_found && req_i[cand]) begin
                pick_idx = cand;
                pick_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_o <= '0;
            last_q <= 2'd3;
        end else if (grant_o != '0) begin
            // owner let go
            if ((grant_o & req_i) == '0)
                grant_o <= '0;
        end else if (pick_found) begin
            grant_o <= req_vec_t'(4'b0001 << pick_idx);
            last_q <= pick_idx;
        end
    end

endmodule

/* source/vfb_defines.svh */
`ifndef VFB_DEFINES_SVH
`define VFB_DEFINES_SVH

// frame geometry, cut down for simulation
`define VFB_FRAME_WORDS 64
`define VFB_BURST 8

// gap of 32 words between buffers
`define VFB_BUFFER_STRIDE (`VFB_FRAME_WORDS + 32)

// cycles to wait after the memory reports init_done
`define VFB_MEM_INIT_DELAY 152

`define VFB_ADDR_W 21
`define VFB_DATA_W 32
`define VFB_PIX_ADDR_W 10
`define VFB_NUM_BUFFERS 3

`endif

/* source/vfb_pkg.sv */
`include "vfb_defines.svh"

package vfb_pkg;

    typedef logic [`VFB_ADDR_W-1:0] mem_addr_t;
    typedef logic [`VFB_DATA_W-1:0] mem_data_t;
    typedef logic [`VFB_PIX_ADDR_W-1:0] pix_addr_t;
    typedef logic [1:0] buf_idx_t;
    typedef logic [3:0] req_vec_t;

    // arbiter peers
    localparam int PEER_UP_TABLE = 0;
    localparam int PEER_DN_TABLE = 1;
    localparam int PEER_WRITER = 2;
    localparam int PEER_READER = 3;

    typedef enum logic [2:0] {
        BUF_AVAILABLE,
        BUF_WRITE_BUSY,
        BUF_READ_BUSY,
        BUF_DISPLAYED,
        BUF_UPDATED
    } buf_state_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_START_WAIT,
        SEQ_LOCK,
        SEQ_SELECT,
        SEQ_START,
        SEQ_XFER_WAIT,
        SEQ_RELEASE_WAIT,
        SEQ_RELEASE
    } seq_state_t;

    typedef enum logic [1:0] {
        BURST_IDLE,
        BURST_REQ,
        BURST_ISSUE,
        BURST_DRAIN
    } burst_state_t;

endpackage

/* source/video_frame_buffer.sv */
`timescale 1ns/1ps
`include "vfb_defines.svh"

module video_frame_buffer import vfb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      init_done_i,
    input  mem_data_t rd_data_i,
    input  logic      rd_data_valid_i,
    output mem_addr_t addr_o,
    output logic      cmd_o,
    output logic      cmd_en_o,
    output mem_data_t wr_data_o,
    output logic      load_read_rdy_o,
    output pix_addr_t load_mem_addr_o,
    input  logic      load_command_valid_i,
    input  mem_data_t load_pixel_data_i,
    input  logic      store_queue_full_i,
    output logic      store_wr_en_o,
    output mem_data_t store_queue_data_o
);

    localparam int DLY_W = $clog2(`VFB_MEM_INIT_DELAY + 1);

    logic [DLY_W-1:0] delay_q;
    logic             mem_ready;
    req_vec_t         req;
    req_vec_t         grant;
    logic             up_req;
    logic             dn_req;
    logic             wr_req;
    logic             rd_req;
    logic             up_select;
    logic             up_release;
    logic             dn_select;
    logic             dn_release;
    logic             up_start;
    logic             dn_start;
    logic             up_done;
    logic             dn_done;
    mem_addr_t        up_base;
    mem_addr_t        dn_base;
    logic             wr_cmd_en;
    logic             rd_cmd_en;
    mem_addr_t        wr_addr;
    mem_addr_t        rd_addr;
    mem_data_t        wr_data;

    // start-up delay, counts only while the memory says it is ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            delay_q <= '0;
        else if (init_done_i && !mem_ready)
            delay_q <= delay_q + 1'b1;
    end

    assign mem_ready = delay_q == DLY_W'(`VFB_MEM_INIT_DELAY);

    always_comb begin
        req = '0;
        req[PEER_UP_TABLE] = up_req;
        req[PEER_DN_TABLE] = dn_req;
        req[PEER_WRITER] = wr_req;
        req[PEER_READER] = rd_req;
    end

    // at most one engine holds the memory grant
    assign cmd_en_o = wr_cmd_en | rd_cmd_en;
    assign cmd_o = wr_cmd_en;
    assign addr_o = wr_cmd_en ? wr_addr : (rd_cmd_en ? rd_addr : '0);
    assign wr_data_o = wr_cmd_en ? wr_data : '0;

    vfb_arbiter arbiter_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req),
        .grant_o (grant)
    );

    frame_buffer_table table_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .up_select_i  (up_select),
        .up_release_i (up_release),
        .dn_select_i  (dn_select),
        .dn_release_i (dn_release),
        .up_base_o    (up_base),
        .dn_base_o    (dn_base)
    );

    frame_sequencer up_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_ready_i (mem_ready),
        .grant_i     (grant[PEER_UP_TABLE]),
        .req_o       (up_req),
        .select_o    (up_select),
        .release_o   (up_release),
        .start_o     (up_start),
        .done_i      (up_done)
    );

    frame_sequencer dn_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_ready_i (mem_ready),
        .grant_i     (grant[PEER_DN_TABLE]),
        .req_o       (dn_req),
        .select_o    (dn_select),
        .release_o   (dn_release),
        .start_o     (dn_start),
        .done_i      (dn_done)
    );

    frame_writer writer_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .start_i              (up_start),
        .base_addr_i          (up_base),
        .grant_i              (grant[PEER_WRITER]),
        .req_o                (wr_req),
        .load_read_rdy_o      (load_read_rdy_o),
        .load_mem_addr_o      (load_mem_addr_o),
        .load_command_valid_i (load_command_valid_i),
        .load_pixel_data_i    (load_pixel_data_i),
        .cmd_en_o             (wr_cmd_en),
        .addr_o               (wr_addr),
        .wr_data_o            (wr_data),
        .done_o               (up_done)
    );

    frame_reader reader_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .start_i            (dn_start),
        .base_addr_i        (dn_base),
        .grant_i            (grant[PEER_READER]),
        .req_o              (rd_req),
        .cmd_en_o           (rd_cmd_en),
        .addr_o             (rd_addr),
        .rd_data_i          (rd_data_i),
        .rd_data_valid_i    (rd_data_valid_i),
        .store_queue_full_i (store_queue_full_i),
        .store_wr_en_o      (store_wr_en_o),
        .store_queue_data_o (store_queue_data_o),
        .done_o             (dn_done)
    );

endmodule

/* test/vfb_assert.sv */
`timescale 1ns/1ps

module vfb_assert import vfb_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input req_vec_t req_i,
    input req_vec_t grant_i,
    input logic     wr_cmd_en_i,
    input logic     rd_cmd_en_i
);

    int unsigned fail_cnt = 0;

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant_i))
    else begin
        fail_cnt++;
        $error("arbiter grant is not one-hot: %b", grant_i);
    end

    // owner keeps the grant for as long as it asks
    grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        ((grant_i & req_i) != '0) |=> (grant_i == $past(grant_i)))
    else begin
        fail_cnt++;
        $error("grant moved while its request was still high");
    end

    wr_cmd_granted: assert property (@(posedge clk) disable iff (!rst_n)
        wr_cmd_en_i |-> grant_i[PEER_WRITER])
    else begin
        fail_cnt++;
        $error("writer issued a memory command without the grant");
    end

    rd_cmd_granted: assert property (@(posedge clk) disable iff (!rst_n)
        rd_cmd_en_i |-> grant_i[PEER_READER])
    else begin
        fail_cnt++;
        $error("reader issued a memory command without the grant");
    end

endmodule

/* test/vfb_tb.sv */
`timescale 1ns/1ps
`include "vfb_defines.svh"

module vfb_tb import vfb_pkg::*; ();

    localparam int STRIDE = `VFB_BUFFER_STRIDE;
    localparam int FRAME_WORDS = `VFB_FRAME_WORDS;
    localparam int MEM_WORDS = `VFB_NUM_BUFFERS * `VFB_BUFFER_STRIDE;
    localparam int NUM_TESTS = 4;
    localparam int RESET_CYCLES = 10;
    localparam int INIT_GAP = 20;
    localparam int FULL_NEVER = 0;
    localparam int FULL_ALT = 1;
    localparam int FULL_RAND = 2;

    logic      clk;
    logic      rst_n;
    logic      init_done;
    mem_data_t rd_data = '0;
    logic      rd_data_valid = 1'b0;
    mem_addr_t addr;
    logic      cmd;
    logic      cmd_en;
    mem_data_t wr_data;
    logic      load_rdy;
    pix_addr_t load_addr;
    logic      load_valid = 1'b0;
    mem_data_t load_data = '0;
    logic      store_full = 1'b0;
    logic      store_wr_en;
    mem_data_t store_data;

    // test table
    string names [NUM_TESTS];
    int    lat_tab [NUM_TESTS];
    int    mode_tab [NUM_TESTS];
    int    frames_tab [NUM_TESTS];

    integer    seed = 36505;
    mem_data_t mem_model [MEM_WORDS];
    mem_data_t resp_data [$];
    int        resp_due [$];
    mem_data_t exp_store [$];
    mem_data_t exp_wdata [$];
    pix_addr_t exp_widx [$];
    logic      fetch_pending = 1'b0;
    pix_addr_t fetch_idx = '0;

    bit    active = 1'b0;
    string cur_name = "";
    int    cur_lat = 1;
    int    cur_mode = FULL_NEVER;
    int    cyc = 0;
    int    limit = 0;
    int    init_cnt;
    int    store_cnt;
    int    rd_cnt;
    int    test_errors;
    int    rd_next;
    int    wr_buf_act;
    int    rd_buf_act;
    bit    first_wr_seen;
    bit    first_rd_seen;
    int    total_errors = 0;
    int    failed_tests = 0;

    video_frame_buffer dut_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .init_done_i          (init_done),
        .rd_data_i            (rd_data),
        .rd_data_valid_i      (rd_data_valid),
        .addr_o               (addr),
        .cmd_o                (cmd),
        .cmd_en_o             (cmd_en),
        .wr_data_o            (wr_data),
        .load_read_rdy_o      (load_rdy),
        .load_mem_addr_o      (load_addr),
        .load_command_valid_i (load_valid),
        .load_pixel_data_i    (load_data),
        .store_queue_full_i   (store_full),
        .store_wr_en_o        (store_wr_en),
        .store_queue_data_o   (store_data)
    );

    bind vfb_arbiter vfb_assert arb_assert_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .grant_i     (grant_o),
        .wr_cmd_en_i (1'b0),
        .rd_cmd_en_i (1'b0)
    );

    bind video_frame_buffer vfb_assert top_assert_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req),
        .grant_i     (grant),
        .wr_cmd_en_i (wr_cmd_en),
        .rd_cmd_en_i (rd_cmd_en)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic flag_error(input string what);
        $display("[ERROR] %s: %s", cur_name, what);
        test_errors++;
    endtask

    task automatic check_data(input string what, input mem_data_t exp, input mem_data_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string what, input mem_addr_t exp, input mem_addr_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_buf(input string what, input buf_idx_t exp, input buf_idx_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: %s expected %0d actual %0d", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic take_write();
        int a;
        int b;
        int off;
        a = int'(addr);
        b = a / STRIDE;
        off = a % STRIDE;
        if (exp_wdata.size() == 0) begin
            flag_error("memory write with no load-queue word behind it");
        end else if (b >= `VFB_NUM_BUFFERS) begin
            flag_error("write address beyond the last buffer");
        end else begin
            check_data("write data", exp_wdata.pop_front(), wr_data);
            check_addr("write offset", mem_addr_t'(exp_widx.pop_front()), mem_addr_t'(off));
            mem_model[a] = wr_data;
            if (!first_wr_seen) begin
                first_wr_seen = 1'b1;
                check_buf("first write buffer", buf_idx_t'(0), buf_idx_t'(b));
                check_addr("first write offset", '0, mem_addr_t'(off));
            end
            if (off == 0)
                wr_buf_act = b;
            if (b == rd_buf_act)
                flag_error("write into the buffer that is being read");
            if (off == FRAME_WORDS - 1)
                wr_buf_act = -1;
        end
    endtask

    task automatic take_read();
        int a;
        int b;
        int off;
        a = int'(addr);
        b = a / STRIDE;
        off = a % STRIDE;
        rd_cnt++;
        if (b >= `VFB_NUM_BUFFERS || off >= FRAME_WORDS) begin
            flag_error("read address outside every frame");
        end else begin
            if (!first_rd_seen) begin
                first_rd_seen = 1'b1;
                check_buf("first read buffer", buf_idx_t'(1), buf_idx_t'(b));
            end
            check_addr("read offset", mem_addr_t'(rd_next), mem_addr_t'(off));
            rd_next = (off + 1) % FRAME_WORDS;
            if (off == 0)
                rd_buf_act = b;
            if (b == wr_buf_act)
                flag_error("read from the buffer that is being written");
            exp_store.push_back(mem_model[a]);
            resp_data.push_back(mem_model[a]);
            resp_due.push_back(cyc + cur_lat - 1);
        end
    endtask

    task automatic take_store();
        if (store_full)
            flag_error("store queue written while it was full");
        if (exp_store.size() == 0)
            flag_error("store word with no memory read behind it");
        else
            check_data("store data", exp_store.pop_front(), store_data);
        store_cnt++;
        if (store_cnt % FRAME_WORDS == 0)
            rd_buf_act = -1;
    endtask

    // memory model, load queue model and checkers sample here
    always @(posedge clk) begin
        cyc++;
        if (!active) begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem_model[i] = '0;
            resp_data.delete();
            resp_due.delete();
            exp_store.delete();
            exp_wdata.delete();
            exp_widx.delete();
            init_cnt = 0;
            store_cnt = 0;
            rd_cnt = 0;
            test_errors = 0;
            rd_next = 0;
            wr_buf_act = -1;
            rd_buf_act = -1;
            first_wr_seen = 1'b0;
            first_rd_seen = 1'b0;
        end else begin
            if (cmd_en && init_cnt < `VFB_MEM_INIT_DELAY)
                flag_error("memory command before the start-up delay ran out");
            if (init_done)
                init_cnt++;
            if (cmd_en && cmd)
                take_write();
            else if (cmd_en)
                take_read();
            if (store_wr_en)
                take_store();
        end
    end

    always @(negedge clk) begin
        if (!active) begin
            rd_data_valid = 1'b0;
            load_valid = 1'b0;
            store_full = 1'b0;
            fetch_pending = 1'b0;
        end else begin
            if (resp_due.size() > 0 && resp_due[0] <= cyc) begin
                rd_data_valid = 1'b1;
                rd_data = resp_data.pop_front();
                resp_due.delete(0);
            end else begin
                rd_data_valid = 1'b0;
            end
            // answer the fetch from one cycle back
            load_valid = fetch_pending;
            if (fetch_pending) begin
                load_data = mem_data_t'($random(seed));
                exp_wdata.push_back(load_data);
                exp_widx.push_back(fetch_idx);
            end
            fetch_pending = load_rdy;
            fetch_idx = load_addr;
            case (cur_mode)
                FULL_ALT: store_full = ~store_full;
                FULL_RAND: store_full = ($random(seed) % 2) != 0;
                default: store_full = 1'b0;
            endcase
        end
    end

    task automatic set_row(input int t, input string name, input int lat, input int mode,
                           input int frames);
        names[t] = name;
        lat_tab[t] = lat;
        mode_tab[t] = mode;
        frames_tab[t] = frames;
    endtask

    task automatic run_test(input int t);
        int target;
        int errs;
        target = frames_tab[t] * FRAME_WORDS;
        @(negedge clk);
        active = 1'b0;
        rst_n = 1'b0;
        init_done = 1'b0;
        cur_name = names[t];
        cur_lat = lat_tab[t];
        cur_mode = mode_tab[t];
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        active = 1'b1;
        repeat (INIT_GAP) @(negedge clk);
        init_done = 1'b1;
        while (store_cnt < target)
            @(negedge clk);
        errs = test_errors;
        // the next frame cannot issue a read before release and relock
        if (rd_cnt != target) begin
            $display("[ERROR] %s: read words expected %0d actual %0d", cur_name, target,
                     rd_cnt);
            errs++;
        end
        $display("test %s: %0d frames, %0d store words, %0d errors", cur_name,
                 frames_tab[t], store_cnt, errs);
        total_errors += errs;
        if (errs != 0)
            failed_tests++;
    endtask

    initial begin
        rst_n = 1'b0;
        init_done = 1'b0;
        set_row(0, "basic", 1, FULL_NEVER, 3);
        set_row(1, "slow_mem", 6, FULL_NEVER, 3);
        set_row(2, "alt_full", 2, FULL_ALT, 3);
        set_row(3, "rand_full", 3, FULL_RAND, 4);
        // start-up plus a generous per-word budget for every row
        for (int t = 0; t < NUM_TESTS; t++)
            limit += RESET_CYCLES + INIT_GAP + 2 + `VFB_MEM_INIT_DELAY
                   + frames_tab[t] * FRAME_WORDS * (lat_tab[t] + 4) * 2;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        total_errors += int'(dut_i.top_assert_i.fail_cnt);
        total_errors += int'(dut_i.arbiter_i.arb_assert_i.fail_cnt);
        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        @(posedge clk);
        while (cyc < limit)
            @(posedge clk);
        $display("[ERROR] %s: no finish within %0d cycles", cur_name, limit);
        $display("sim failed");
        $finish;
    end

endmodule
